// File: pix_pkg.sv
package pix_pkg;

  localparam int PIX_W = 8;
  localparam int N_SCALES = 4;  // Blur scales kept per image row

  typedef logic [PIX_W-1:0] pixel_t;
  typedef logic signed [PIX_W:0] diff_t;
  typedef logic [PIX_W:0] mag_t;  // Magnitude of a diff_t

  // Difference of two unsigned pixels, one extra bit so it never wraps
  function automatic diff_t pix_diff(input pixel_t a, input pixel_t b);
    return diff_t'({1'b0, a}) - diff_t'({1'b0, b});
  endfunction

  function automatic mag_t pix_mag(input diff_t d);
    if (d[PIX_W]) begin
      return mag_t'(-d);
    end
    return mag_t'(d);
  endfunction

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

  // Pass modes seen by the line buffer and the detector
  typedef enum logic [2:0] {
    MODE_IDLE     = 3'd0,
    MODE_GAUSSIAN = 3'd1,
    MODE_DETECT   = 3'd2,
    MODE_MATCH    = 3'd3,  // Descriptor pass, not built here
    MODE_END      = 3'd4
  } sys_mode_e;

endpackage

// File: row_ram.sv
`timescale 1ns/1ps

module row_ram #(
  parameter type row_t = logic [63:0],
  parameter int DEPTH = 8,
  localparam int AW = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          we,
  input  logic [AW-1:0] waddr,
  input  row_t          wdata,
  input  logic [AW-1:0] raddr,
  output row_t          rdata
);

  row_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // Old data on a same-address write
  end

endmodule

// File: scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl #(
  parameter int IMG_ROWS = 8,
  localparam int ROW_W = $clog2(IMG_ROWS)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                busy,
  output ctrl_pkg::sys_mode_e buffer_mode,
  output logic [ROW_W-1:0]    rd_addr,
  output logic                buffer_we,
  output logic                fill_zero,
  output logic                blur_we,
  output logic [ROW_W-1:0]    blur_addr,
  output logic [ROW_W-1:0]    kp_row,
  output logic                done
);

  typedef enum logic [2:0] {PH_IDLE, PH_GAUSS, PH_CLEAR, PH_DETECT, PH_END} phase_e;

  localparam int CNT_W = $clog2(IMG_ROWS + 4);
  localparam int GAUSS_LAST = IMG_ROWS + 3;  // Last blur write
  localparam int DET_LAST = IMG_ROWS + 1;    // Last keypoint strobe

  phase_e           phase;
  logic [CNT_W-1:0] cnt;
  logic             rd_req;
  logic             launch;

  assign busy   = (phase != PH_IDLE) && (phase != PH_END);
  assign done   = (phase == PH_END);
  assign launch = start && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end else begin
      case (phase)
        PH_IDLE, PH_END: begin
          cnt   <= '0;
          phase <= launch ? PH_GAUSS : PH_IDLE;
        end
        PH_GAUSS: begin
          if (cnt == CNT_W'(GAUSS_LAST)) begin
            phase <= PH_CLEAR;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PH_CLEAR: phase <= PH_DETECT;
        PH_DETECT: begin
          if (cnt == CNT_W'(DET_LAST)) begin
            phase <= PH_END;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  always_comb begin
    buffer_mode = ctrl_pkg::MODE_IDLE;  // Also the clear cycle
    rd_req      = 1'b0;
    rd_addr     = '0;
    fill_zero   = 1'b0;
    blur_we     = 1'b0;
    blur_addr   = '0;
    case (phase)
      PH_IDLE: rd_req = launch;  // Row 0 is fetched as start is taken
      PH_GAUSS: begin
        buffer_mode = ctrl_pkg::MODE_GAUSSIAN;
        rd_req      = cnt < CNT_W'(IMG_ROWS - 1);
        rd_addr     = ROW_W'(cnt + 1'b1);
        fill_zero   = (cnt >= CNT_W'(IMG_ROWS)) && (cnt < CNT_W'(IMG_ROWS + 3));
        blur_we     = cnt >= CNT_W'(4);  // Row 3 of the window is now valid
        blur_addr   = ROW_W'(cnt - CNT_W'(4));
      end
      PH_DETECT: begin
        buffer_mode = ctrl_pkg::MODE_DETECT;
        rd_req      = cnt < CNT_W'(IMG_ROWS);
        rd_addr     = ROW_W'(cnt);
      end
      PH_END: begin
        buffer_mode = ctrl_pkg::MODE_END;
        rd_req      = launch;
      end
      default: ;
    endcase
  end

  // Store read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      buffer_we <= 1'b0;
    end else begin
      buffer_we <= rd_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      kp_row <= rd_addr;
    end
  end

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
  parameter int LINE_PIX = 8,
  localparam int ROW_W = LINE_PIX * pix_pkg::PIX_W
) (
  input  logic                clk,
  input  logic                rst_n,
  input  ctrl_pkg::sys_mode_e buffer_mode,
  input  logic                buffer_we,
  input  logic                fill_zero,
  input  logic [ROW_W-1:0]    img_data,
  input  logic [ROW_W-1:0]    blur_data_0,
  input  logic [ROW_W-1:0]    blur_data_1,
  input  logic [ROW_W-1:0]    blur_data_2,
  input  logic [ROW_W-1:0]    blur_data_3,
  output logic [ROW_W-1:0]    buffer_data_0,
  output logic [ROW_W-1:0]    buffer_data_1,
  output logic [ROW_W-1:0]    buffer_data_2,
  output logic [ROW_W-1:0]    buffer_data_3,
  output logic [ROW_W-1:0]    buffer_data_4,
  output logic [ROW_W-1:0]    buffer_data_5,
  output logic [ROW_W-1:0]    buffer_data_6,
  output logic [ROW_W-1:0]    buffer_data_7,
  output logic [ROW_W-1:0]    buffer_data_8,
  output logic [ROW_W-1:0]    buffer_data_9
);

  localparam int N_ROWS = 2 + 2 * pix_pkg::N_SCALES;  // Image pair plus one pair per scale
  localparam int WIN = 6;                             // Gaussian window height

  logic [ROW_W-1:0] rows [N_ROWS];
  logic [ROW_W-1:0] blur_in [pix_pkg::N_SCALES];

  assign blur_in[0] = blur_data_0;
  assign blur_in[1] = blur_data_1;
  assign blur_in[2] = blur_data_2;
  assign blur_in[3] = blur_data_3;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < N_ROWS; k++) begin
        rows[k] <= '0;
      end
    end else begin
      case (buffer_mode)
        ctrl_pkg::MODE_GAUSSIAN: begin
          if (buffer_we) begin
            rows[0] <= img_data;
          end else if (fill_zero) begin
            rows[0] <= '0;  // Bottom padding
          end
          for (int k = 1; k < WIN; k++) begin
            rows[k] <= rows[k-1];
          end
        end
        ctrl_pkg::MODE_DETECT: begin
          if (buffer_we) begin
            rows[0] <= img_data;
            for (int s = 0; s < pix_pkg::N_SCALES; s++) begin
              rows[2*s+2] <= blur_in[s];
            end
            // Odd rows keep the previous image row of each pair
            for (int k = 1; k < N_ROWS; k += 2) begin
              rows[k] <= rows[k-1];
            end
          end
        end
        default: begin
          for (int k = 0; k < N_ROWS; k++) begin
            rows[k] <= '0;
          end
        end
      endcase
    end
  end

  assign buffer_data_0 = rows[0];
  assign buffer_data_1 = rows[1];
  assign buffer_data_2 = rows[2];
  assign buffer_data_3 = rows[3];
  assign buffer_data_4 = rows[4];
  assign buffer_data_5 = rows[5];
  assign buffer_data_6 = rows[6];
  assign buffer_data_7 = rows[7];
  assign buffer_data_8 = rows[8];
  assign buffer_data_9 = rows[9];

endmodule

// File: gauss_column.sv
`timescale 1ns/1ps

module gauss_column #(
  parameter int LINE_PIX = 8,
  localparam int ROW_W = LINE_PIX * pix_pkg::PIX_W
) (
  input  logic [ROW_W-1:0]                   win_0,
  input  logic [ROW_W-1:0]                   win_1,
  input  logic [ROW_W-1:0]                   win_2,
  input  logic [ROW_W-1:0]                   win_3,
  input  logic [ROW_W-1:0]                   win_4,
  input  logic [ROW_W-1:0]                   win_5,
  output logic [pix_pkg::N_SCALES*ROW_W-1:0] blur_set
);

  localparam int PW = pix_pkg::PIX_W;
  localparam int SUM_W = PW + 5;  // Widest sum has weight 32

  for (genvar i = 0; i < LINE_PIX; i++) begin : g_col
    pix_pkg::pixel_t  p [6];
    logic [SUM_W-1:0] s1;
    logic [SUM_W-1:0] s2;
    logic [SUM_W-1:0] s3;

    assign p[0] = win_0[i*PW +: PW];
    assign p[1] = win_1[i*PW +: PW];
    assign p[2] = win_2[i*PW +: PW];
    assign p[3] = win_3[i*PW +: PW];  // Centre row
    assign p[4] = win_4[i*PW +: PW];
    assign p[5] = win_5[i*PW +: PW];

    assign s1 = SUM_W'(p[2] + 2 * p[3] + p[4]);
    assign s2 = SUM_W'(p[1] + 4 * p[2] + 6 * p[3] + 4 * p[4] + p[5]);
    assign s3 = SUM_W'(p[0] + 5 * p[1] + 10 * p[2] + 10 * p[3] + 5 * p[4] + p[5]);

    // Scale s lives at s * ROW_W, floor division by dropping low bits
    assign blur_set[0*ROW_W + i*PW +: PW] = p[3];
    assign blur_set[1*ROW_W + i*PW +: PW] = s1[PW+1:2];
    assign blur_set[2*ROW_W + i*PW +: PW] = s2[PW+3:4];
    assign blur_set[3*ROW_W + i*PW +: PW] = s3[PW+4:5];
  end

endmodule

// File: dog_detect.sv
`timescale 1ns/1ps

module dog_detect #(
  parameter int LINE_PIX = 8,
  parameter int IMG_ROWS = 8,
  parameter int THRESH = 8,
  parameter int EDGE_LIM = 64,
  localparam int ROW_W = LINE_PIX * pix_pkg::PIX_W,
  localparam int ADDR_W = $clog2(IMG_ROWS)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  ctrl_pkg::sys_mode_e buffer_mode,
  input  logic                load,
  input  logic [ADDR_W-1:0]   kp_row_in,
  input  logic [ROW_W-1:0]    buffer_data_0,
  input  logic [ROW_W-1:0]    buffer_data_1,
  input  logic [ROW_W-1:0]    buffer_data_2,
  input  logic [ROW_W-1:0]    buffer_data_3,
  input  logic [ROW_W-1:0]    buffer_data_4,
  input  logic [ROW_W-1:0]    buffer_data_5,
  input  logic [ROW_W-1:0]    buffer_data_6,
  input  logic [ROW_W-1:0]    buffer_data_7,
  input  logic [ROW_W-1:0]    buffer_data_8,
  input  logic [ROW_W-1:0]    buffer_data_9,
  output logic                kp_valid,
  output logic [ADDR_W-1:0]   kp_row,
  output logic [LINE_PIX-1:0] kp_mask
);

  localparam int PW = pix_pkg::PIX_W;

  logic [LINE_PIX-1:0] mask_c;
  logic                det_load;

  assign det_load = load && (buffer_mode == ctrl_pkg::MODE_DETECT);

  for (genvar i = 0; i < LINE_PIX; i++) begin : g_pix
    pix_pkg::mag_t m01;
    pix_pkg::mag_t m12;
    pix_pkg::mag_t m23;
    pix_pkg::mag_t m12_prev;
    pix_pkg::mag_t m_step;

    assign m01 = pix_pkg::pix_mag(pix_pkg::pix_diff(buffer_data_2[i*PW +: PW],
                                                    buffer_data_4[i*PW +: PW]));
    assign m12 = pix_pkg::pix_mag(pix_pkg::pix_diff(buffer_data_4[i*PW +: PW],
                                                    buffer_data_6[i*PW +: PW]));
    assign m23 = pix_pkg::pix_mag(pix_pkg::pix_diff(buffer_data_6[i*PW +: PW],
                                                    buffer_data_8[i*PW +: PW]));
    assign m12_prev = pix_pkg::pix_mag(pix_pkg::pix_diff(buffer_data_5[i*PW +: PW],
                                                         buffer_data_7[i*PW +: PW]));
    // Vertical image step, large ones are edges
    assign m_step = pix_pkg::pix_mag(pix_pkg::pix_diff(buffer_data_0[i*PW +: PW],
                                                       buffer_data_1[i*PW +: PW]));

    assign mask_c[i] = (m12 >= THRESH) && (m12 > m01) && (m12 > m23) &&
                       (m12 > m12_prev) && (m_step <= EDGE_LIM);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      kp_valid <= 1'b0;
    end else begin
      kp_valid <= det_load;
    end
  end

  always_ff @(posedge clk) begin
    if (det_load) begin
      kp_row <= kp_row_in;
    end
  end

  // Buffer holds the loaded row while kp_valid is high
  assign kp_mask = mask_c;

endmodule

// File: keypoint_top.sv
`timescale 1ns/1ps

module keypoint_top #(
  parameter int LINE_PIX = 8,
  parameter int IMG_ROWS = 8,
  parameter int THRESH = 8,
  parameter int EDGE_LIM = 64,
  localparam int ROW_W = LINE_PIX * pix_pkg::PIX_W,
  localparam int ADDR_W = $clog2(IMG_ROWS)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_we,
  input  logic [ADDR_W-1:0]   load_addr,
  input  logic [ROW_W-1:0]    load_row,
  input  logic                start,
  output logic                busy,
  output logic                kp_valid,
  output logic [ADDR_W-1:0]   kp_row,
  output logic [LINE_PIX-1:0] kp_mask,
  output logic                done
);

  localparam int BLUR_W = pix_pkg::N_SCALES * ROW_W;

  ctrl_pkg::sys_mode_e buffer_mode;
  logic                buffer_we;
  logic                fill_zero;
  logic                blur_we;
  logic [ADDR_W-1:0]   rd_addr;
  logic [ADDR_W-1:0]   blur_addr;
  logic [ADDR_W-1:0]   ctrl_kp_row;
  logic [ROW_W-1:0]    img_rd;
  logic [BLUR_W-1:0]   blur_set;
  logic [BLUR_W-1:0]   blur_rd;
  logic [ROW_W-1:0]    bd0, bd1, bd2, bd3, bd4, bd5, bd6, bd7, bd8, bd9;

  row_ram #(.row_t(logic [ROW_W-1:0]), .DEPTH(IMG_ROWS)) img_store (
    .clk(clk), .we(load_we), .waddr(load_addr), .wdata(load_row),
    .raddr(rd_addr), .rdata(img_rd)
  );

  row_ram #(.row_t(logic [BLUR_W-1:0]), .DEPTH(IMG_ROWS)) blur_store (
    .clk(clk), .we(blur_we), .waddr(blur_addr), .wdata(blur_set),
    .raddr(rd_addr), .rdata(blur_rd)
  );

  scan_ctrl #(.IMG_ROWS(IMG_ROWS)) u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .buffer_mode(buffer_mode),
    .rd_addr(rd_addr), .buffer_we(buffer_we), .fill_zero(fill_zero), .blur_we(blur_we),
    .blur_addr(blur_addr), .kp_row(ctrl_kp_row), .done(done)
  );

  line_buffer #(.LINE_PIX(LINE_PIX)) u_buf (
    .clk(clk), .rst_n(rst_n), .buffer_mode(buffer_mode), .buffer_we(buffer_we),
    .fill_zero(fill_zero), .img_data(img_rd),
    .blur_data_0(blur_rd[0*ROW_W +: ROW_W]), .blur_data_1(blur_rd[1*ROW_W +: ROW_W]),
    .blur_data_2(blur_rd[2*ROW_W +: ROW_W]), .blur_data_3(blur_rd[3*ROW_W +: ROW_W]),
    .buffer_data_0(bd0), .buffer_data_1(bd1), .buffer_data_2(bd2), .buffer_data_3(bd3),
    .buffer_data_4(bd4), .buffer_data_5(bd5), .buffer_data_6(bd6), .buffer_data_7(bd7),
    .buffer_data_8(bd8), .buffer_data_9(bd9)
  );

  gauss_column #(.LINE_PIX(LINE_PIX)) u_gauss (
    .win_0(bd0), .win_1(bd1), .win_2(bd2), .win_3(bd3), .win_4(bd4), .win_5(bd5),
    .blur_set(blur_set)
  );

  dog_detect #(
    .LINE_PIX(LINE_PIX), .IMG_ROWS(IMG_ROWS), .THRESH(THRESH), .EDGE_LIM(EDGE_LIM)
  ) u_dog (
    .clk(clk), .rst_n(rst_n), .buffer_mode(buffer_mode), .load(buffer_we),
    .kp_row_in(ctrl_kp_row),
    .buffer_data_0(bd0), .buffer_data_1(bd1), .buffer_data_2(bd2), .buffer_data_3(bd3),
    .buffer_data_4(bd4), .buffer_data_5(bd5), .buffer_data_6(bd6), .buffer_data_7(bd7),
    .buffer_data_8(bd8), .buffer_data_9(bd9),
    .kp_valid(kp_valid), .kp_row(kp_row), .kp_mask(kp_mask)
  );

endmodule

// File: tb_clk.sv
`timescale 1ns/1ps

module tb_clk #(
  parameter int HALF_NS = 10  // 20 ns period
) (
  output logic clk
);

  initial clk = 1'b0;
  always #HALF_NS clk = ~clk;

endmodule

// File: keypoint_asserts.sv
`timescale 1ns/1ps

module keypoint_asserts #(
  parameter int IMG_ROWS = 8,
  localparam int ADDR_W = $clog2(IMG_ROWS)
) (
  input logic              clk,
  input logic              rst_n,
  input logic              start,
  input logic              busy,
  input logic              kp_valid,
  input logic [ADDR_W-1:0] kp_row,
  input logic              done
);

  localparam logic [ADDR_W-1:0] LAST_ROW = ADDR_W'(IMG_ROWS - 1);

  reset_quiet: assert property (@(posedge clk) $past(!rst_n) |-> !kp_valid && !done)
    else $error("kp_valid or done high right after a reset edge");

  done_follows_last: assert property (@(posedge clk) disable iff (!rst_n)
    $past(kp_valid && kp_row == LAST_ROW) |-> done)
    else $error("done missing one cycle after the last row strobe");

  done_only_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(kp_valid && kp_row == LAST_ROW))
    else $error("done without a last row strobe before it");

  busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> done)
    else $error("busy fell without done");

  // First strobe of a run at a fixed distance from the accepted start
  first_row_latency: assert property (@(posedge clk) disable iff (!rst_n)
    kp_valid && kp_row == '0 |-> $past(start && !busy, IMG_ROWS + 8))
    else $error("first keypoint row not IMG_ROWS+8 cycles after start");

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int LINE_PIX = 8;
  localparam int IMG_ROWS = 8;
  localparam int THRESH = 8;
  localparam int EDGE_LIM = 64;
  localparam int ADDR_W = $clog2(IMG_ROWS);
  localparam int PW = pix_pkg::PIX_W;
  localparam int ROW_W = LINE_PIX * PW;
  localparam int MAX_CYCLES = 2000;  // Eight runs of about 40 cycles plus loads

  logic                clk;
  logic                rst_n;
  logic                load_we;
  logic [ADDR_W-1:0]   load_addr;
  logic [ROW_W-1:0]    load_row;
  logic                start;
  logic                busy;
  logic                kp_valid;
  logic [ADDR_W-1:0]   kp_row;
  logic [LINE_PIX-1:0] kp_mask;
  logic                done;

  int                  img [IMG_ROWS][LINE_PIX];
  logic [LINE_PIX-1:0] exp_mask [IMG_ROWS];
  int                  kp_count = 0;
  int                  done_count = 0;
  int                  cycles = 0;
  bit                  prev_valid = 1'b0;
  bit                  failed = 1'b0;
  bit                  finished = 1'b0;

  tb_clk u_clk (.clk(clk));

  keypoint_top #(
    .LINE_PIX(LINE_PIX), .IMG_ROWS(IMG_ROWS), .THRESH(THRESH), .EDGE_LIM(EDGE_LIM)
  ) dut (
    .clk(clk), .rst_n(rst_n), .load_we(load_we), .load_addr(load_addr),
    .load_row(load_row), .start(start), .busy(busy), .kp_valid(kp_valid),
    .kp_row(kp_row), .kp_mask(kp_mask), .done(done)
  );

  bind keypoint_top keypoint_asserts #(.IMG_ROWS(IMG_ROWS)) u_asserts (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .kp_valid(kp_valid),
    .kp_row(kp_row), .done(done)
  );

  task automatic fail_now(input string what);
    failed = 1'b1;
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  function automatic int pix_at(int r, int c);
    if (r < 0 || r >= IMG_ROWS) begin
      return 0;
    end
    return img[r][c];
  endfunction

  function automatic int abs_int(int v);
    return (v < 0) ? -v : v;
  endfunction

  // Column binomial blur of scale s, rows outside the image are zero
  function automatic int blur_at(int r, int c, int s);
    if (r < 0) begin
      return 0;
    end
    case (s)
      0: return pix_at(r, c);
      1: return (pix_at(r + 1, c) + 2 * pix_at(r, c) + pix_at(r - 1, c)) >> 2;
      2: return (pix_at(r + 2, c) + 4 * pix_at(r + 1, c) + 6 * pix_at(r, c) +
                 4 * pix_at(r - 1, c) + pix_at(r - 2, c)) >> 4;
      default: return (pix_at(r + 3, c) + 5 * pix_at(r + 2, c) + 10 * pix_at(r + 1, c) +
                       10 * pix_at(r, c) + 5 * pix_at(r - 1, c) + pix_at(r - 2, c)) >> 5;
    endcase
  endfunction

  function automatic logic [LINE_PIX-1:0] row_mask(int q);
    logic [LINE_PIX-1:0] m;
    int d01, d12, d23, p12, step;
    m = '0;
    for (int c = 0; c < LINE_PIX; c++) begin
      d01 = abs_int(blur_at(q, c, 0) - blur_at(q, c, 1));
      d12 = abs_int(blur_at(q, c, 1) - blur_at(q, c, 2));
      d23 = abs_int(blur_at(q, c, 2) - blur_at(q, c, 3));
      p12 = abs_int(blur_at(q - 1, c, 1) - blur_at(q - 1, c, 2));
      step = abs_int(pix_at(q, c) - pix_at(q - 1, c));
      m[c] = d12 >= THRESH && d12 > d01 && d12 > d23 && d12 > p12 && step <= EDGE_LIM;
    end
    return m;
  endfunction

  task automatic build_model();
    for (int r = 0; r < IMG_ROWS; r++) begin
      exp_mask[r] = row_mask(r);
    end
  endtask

  task automatic load_image();
    logic [ROW_W-1:0] row;
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < LINE_PIX; c++) begin
        row[c*PW +: PW] = pix_pkg::pixel_t'(img[r][c]);
      end
      @(posedge clk);
      load_we   <= 1'b1;
      load_addr <= ADDR_W'(r);
      load_row  <= row;
    end
    @(posedge clk);
    load_we <= 1'b0;
  endtask

  task automatic run_image(input bit restart_busy);
    build_model();
    load_image();
    kp_count   = 0;
    done_count = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (restart_busy) begin
      repeat (3) @(posedge clk);
      start <= 1'b1;  // Lands while busy
      @(posedge clk);
      start <= 1'b0;
    end
    do @(negedge clk); while (!done);
    repeat (4) @(negedge clk);
    assert (kp_count == IMG_ROWS)
      else fail_now($sformatf("Run gave %0d row strobes instead of %0d", kp_count, IMG_ROWS));
    assert (done_count == 1)
      else fail_now($sformatf("Run gave %0d done pulses instead of one", done_count));
  endtask

  always @(negedge clk) begin
    if (rst_n && kp_valid) begin
      assert (kp_count == 0 || prev_valid)
        else fail_now("Row strobes of one run are not on consecutive cycles");
      assert (kp_row == ADDR_W'(kp_count))
        else fail_now($sformatf("FAIL time=%0t kp_row got %0d expected %0d",
                                $time, kp_row, kp_count));
      assert (kp_mask == exp_mask[kp_row])
        else fail_now($sformatf("FAIL time=%0t kp_mask row %0d got %b expected %b",
                                $time, kp_row, kp_mask, exp_mask[kp_row]));
      kp_count++;
    end
    if (rst_n && done) begin
      done_count++;
    end
    prev_valid = kp_valid;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      fail_now($sformatf("Simulation hung, no end after %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    int seed;
    int span;
    int base;
    seed      = $urandom(32'h3f26b3f7);
    rst_n     = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_row  = '0;
    start     = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) begin
      @(negedge clk);
      assert (!busy && !kp_valid && !done)
        else fail_now("busy, kp_valid or done went high before any start");
    end
    foreach (img[r, c]) img[r][c] = 100;  // Flat image
    run_image(1'b1);
    foreach (img[r, c]) img[r][c] = 0;
    img[3][4] = 200;  // Single bright pixel
    run_image(1'b0);
    foreach (img[r, c]) img[r][c] = (r < 4) ? 10 : 200;  // Step well over EDGE_LIM
    run_image(1'b0);
    for (int k = 0; k < 5; k++) begin
      span = (k < 2) ? 255 : 40;  // Smooth images leave room for keypoints
      base = $urandom_range(0, 255 - span);
      foreach (img[r, c]) img[r][c] = base + int'($urandom_range(0, span));
      run_image(k == 4);
    end
    finished = 1'b1;
    $display("All tests passed");
    $finish;
  end

  // A stop raised by a bound assertion ends the run early
  final begin
    if (!finished && !failed) begin
      $display("Some tests failed");
    end
  end

endmodule

// File: project.f
pix_pkg.sv
ctrl_pkg.sv
row_ram.sv
scan_ctrl.sv
line_buffer.sv
gauss_column.sv
dog_detect.sv
keypoint_top.sv
tb_clk.sv
keypoint_asserts.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the keypoint testbench, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f project.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
